/* source/msx_cart_pkg.sv */
package msx_cart_pkg;

    // Width of the ROM size and of every ROM byte address.
    localparam int ROM_SIZE_W = 27;

    // ************************************************************************
    // Cartridge mapper types
    // ************************************************************************
    typedef enum logic [2:0] {
        MAPPER_UNUSED     = 3'd0,  // Plain ROM without bank switching.
        MAPPER_KONAMI     = 3'd1,
        MAPPER_KONAMI_SCC = 3'd2,
        MAPPER_ASCII8     = 3'd3,
        MAPPER_ASCII16    = 3'd4
    } mapper_typ_t;

    // Operation sent from the write decoder to the bank register file.
    typedef enum logic [1:0] {
        BANK_NONE  = 2'd0,
        BANK_SET8  = 2'd1,  // One 8 KB slot.
        BANK_SET16 = 2'd2   // A pair of 8 KB slots.
    } bank_op_t;

    // ************************************************************************
    // Bus structs
    // ************************************************************************
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd;
        logic        wr;
    } cpu_bus_t;

    typedef struct packed {
        bank_op_t   op;
        logic [1:0] index;
        logic [7:0] value;
    } bank_wr_t;

    // Bank numbers in 8 KB units for the slots at 0x4000, 0x6000, 0x8000 and 0xA000.
    typedef struct packed {
        logic [7:0] bank0;
        logic [7:0] bank1;
        logic [7:0] bank2;
        logic [7:0] bank3;
    } bank_set_t;

endpackage

/* source/mapper_detect.sv */
`timescale 1ns/1ps

module mapper_detect (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [7:0]                          data,
    input  logic                                wr,
    input  logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_size,
    output msx_cart_pkg::mapper_typ_t           mapper,
    output logic [3:0]                          offset
);
    import msx_cart_pkg::*;

    // Line of eight bytes that holds the second header at image offset 0x4000.
    localparam logic [ROM_SIZE_W-4:0] HEAD4_LINE = 'h800;

    logic [ROM_SIZE_W-1:0] load_addr;
    logic [7:0]            prev1;       // Byte before the current one.
    logic [7:0]            prev2;       // Two bytes before the current one.
    logic                  store_hit;
    logic signed [15:0]    asc8_cnt;
    logic signed [15:0]    asc16_cnt;
    logic signed [15:0]    kon_cnt;
    logic signed [15:0]    scc_cnt;
    logic signed [15:0]    kon_best;
    logic signed [15:0]    ascii_best;
    logic [7:0]            head0 [8];
    logic [7:0]            head4 [8];
    logic [15:0]           start0;
    logic [15:0]           start4;
    logic                  sig0;
    logic                  sig4;
    logic [3:0]            off_16k;
    logic [3:0]            off_32k;
    logic [3:0]            off_48k;

    // A "ld (nn),a" with a zero low address byte completes on the current byte.
    assign store_hit = prev2 == 8'h32 && prev1 == 8'h00;

    // ************************************************************************
    // Store pattern voting
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            load_addr <= '0;
            prev1     <= 8'h00;
            prev2     <= 8'h00;
            asc8_cnt  <= '0;
            asc16_cnt <= '0;
            kon_cnt   <= '0;
            scc_cnt   <= '0;
        end else if (wr) begin
            load_addr <= load_addr + 1'b1;
            prev2     <= prev1;
            prev1     <= data;
            if (store_hit) begin
                case (data)
                    8'h60, 8'h70: begin
                        asc8_cnt  <= asc8_cnt + 16'sd1;
                        asc16_cnt <= asc16_cnt + 16'sd1;
                    end
                    8'h68, 8'h78: begin  // Only ASCII8 has windows at odd 2 KB steps.
                        asc8_cnt  <= asc8_cnt + 16'sd1;
                        asc16_cnt <= asc16_cnt - 16'sd1;
                    end
                    default: ;
                endcase
                case (data)
                    8'h60, 8'h80, 8'hA0:        kon_cnt <= kon_cnt + 16'sd1;
                    8'h50, 8'h70, 8'h90, 8'hB0: scc_cnt <= scc_cnt + 16'sd1;
                    default: ;
                endcase
            end
        end
    end

    // The second header is cleared at the start of a load, so short images read zeros.
    always_ff @(posedge clk) begin
        if (wr) begin
            if (load_addr[ROM_SIZE_W-1:3] == '0) begin
                head0[load_addr[2:0]] <= data;
                head4[load_addr[2:0]] <= 8'h00;
            end else if (load_addr[ROM_SIZE_W-1:3] == HEAD4_LINE) begin
                head4[load_addr[2:0]] <= data;
            end
        end
    end

    assign kon_best   = kon_cnt > scc_cnt ? kon_cnt : scc_cnt;
    assign ascii_best = asc8_cnt > asc16_cnt ? asc8_cnt : asc16_cnt;

    always_comb begin
        if (rom_size < ROM_SIZE_W'(32'h10000)) begin
            mapper = MAPPER_UNUSED;
        end else if (kon_best >= ascii_best) begin
            mapper = scc_cnt > kon_cnt ? MAPPER_KONAMI_SCC : MAPPER_KONAMI;
        end else begin
            mapper = asc8_cnt > asc16_cnt ? MAPPER_ASCII8 : MAPPER_ASCII16;
        end
    end

    // ************************************************************************
    // Plain ROM placement from the "AB" header
    // ************************************************************************
    assign start0 = {head0[3], head0[2]};
    assign start4 = {head4[3], head4[2]};
    assign sig0   = head0[0] == "A" && head0[1] == "B";
    assign sig4   = head4[0] == "A" && head4[1] == "B";

    always_comb begin
        if (start0 == 16'h0000) begin
            off_16k = head0[5][7:6] != 2'b01 ? 4'h8 : 4'h4;
        end else begin
            off_16k = start0[15:14] == 2'b10 ? 4'h8 : 4'h4;
        end
        off_32k = 4'h4;
        if (!sig0 && sig4) begin
            if (start4 == 16'h0000) begin
                if (head4[5][7:6] == 2'b01) begin
                    off_32k = 4'h0;
                end
            end else if (start4 < 16'h8000 || start4 >= 16'hC000) begin
                off_32k = 4'h0;
            end
        end
        off_48k = (sig0 && !sig4) ? 4'h4 : 4'h0;
    end

    always_comb begin
        case (rom_size)
            ROM_SIZE_W'(32'h4000): offset = off_16k;
            ROM_SIZE_W'(32'h8000): offset = off_32k;
            ROM_SIZE_W'(32'hC000): offset = off_48k;
            default:               offset = 4'h0;
        endcase
    end

endmodule

/* source/cart_bank_decode.sv */
`timescale 1ns/1ps

module cart_bank_decode (
    input  msx_cart_pkg::cpu_bus_t    cpu,
    input  msx_cart_pkg::mapper_typ_t mapper,
    output msx_cart_pkg::bank_wr_t    bank_wr
);
    import msx_cart_pkg::*;

    // Switching windows as address bits 15 to 11.
    localparam logic [4:0] WIN_5000 = 5'h0A;
    localparam logic [4:0] WIN_6000 = 5'h0C;
    localparam logic [4:0] WIN_6800 = 5'h0D;
    localparam logic [4:0] WIN_7000 = 5'h0E;
    localparam logic [4:0] WIN_7800 = 5'h0F;
    localparam logic [4:0] WIN_8000 = 5'h10;
    localparam logic [4:0] WIN_9000 = 5'h12;
    localparam logic [4:0] WIN_A000 = 5'h14;
    localparam logic [4:0] WIN_B000 = 5'h16;

    logic [4:0] win;
    bank_op_t   op;
    logic [1:0] index;

    assign win = cpu.addr[15:11];

    always_comb begin
        op    = BANK_NONE;
        index = 2'd0;
        if (cpu.wr) begin
            case (mapper)
                MAPPER_KONAMI: begin
                    op = BANK_SET8;
                    case (win)
                        WIN_6000: index = 2'd1;  // Slot 0 is fixed on this mapper.
                        WIN_8000: index = 2'd2;
                        WIN_A000: index = 2'd3;
                        default:  op = BANK_NONE;
                    endcase
                end
                MAPPER_KONAMI_SCC: begin
                    op = BANK_SET8;
                    case (win)
                        WIN_5000: index = 2'd0;
                        WIN_7000: index = 2'd1;
                        WIN_9000: index = 2'd2;
                        WIN_B000: index = 2'd3;
                        default:  op = BANK_NONE;
                    endcase
                end
                MAPPER_ASCII8: begin
                    op = BANK_SET8;
                    case (win)
                        WIN_6000: index = 2'd0;
                        WIN_6800: index = 2'd1;
                        WIN_7000: index = 2'd2;
                        WIN_7800: index = 2'd3;
                        default:  op = BANK_NONE;
                    endcase
                end
                MAPPER_ASCII16: begin
                    // Index selects the slot pair at 0x4000 or at 0x8000.
                    op = BANK_SET16;
                    case (win)
                        WIN_6000: index = 2'd0;
                        WIN_7000: index = 2'd1;
                        default:  op = BANK_NONE;
                    endcase
                end
                default: op = BANK_NONE;
            endcase
        end
    end

    assign bank_wr = '{op: op, index: index, value: cpu.data};

endmodule

/* source/cart_bank_regs.sv */
`timescale 1ns/1ps

module cart_bank_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  msx_cart_pkg::bank_wr_t bank_wr,
    output msx_cart_pkg::bank_set_t banks
);
    import msx_cart_pkg::*;

    logic [7:0] bank_q [4];
    logic [1:0] pair_lo;
    logic [1:0] pair_hi;

    assign pair_lo = {bank_wr.index[0], 1'b0};
    assign pair_hi = {bank_wr.index[0], 1'b1};

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_q[0] <= 8'd0;
            bank_q[1] <= 8'd1;
            bank_q[2] <= 8'd2;
            bank_q[3] <= 8'd3;
        end else begin
            case (bank_wr.op)
                BANK_SET8: begin
                    bank_q[bank_wr.index] <= bank_wr.value;
                end
                BANK_SET16: begin
                    // A 16 KB bank n covers the 8 KB banks 2n and 2n+1.
                    bank_q[pair_lo] <= {bank_wr.value[6:0], 1'b0};
                    bank_q[pair_hi] <= {bank_wr.value[6:0], 1'b1};
                end
                default: ;
            endcase
        end
    end

    assign banks = '{
        bank0: bank_q[0],
        bank1: bank_q[1],
        bank2: bank_q[2],
        bank3: bank_q[3]
    };

endmodule

/* source/cart_read_map.sv */
`timescale 1ns/1ps

module cart_read_map (
    input  logic                                clk,
    input  logic                                rst,
    input  msx_cart_pkg::cpu_bus_t              cpu,
    input  msx_cart_pkg::mapper_typ_t           mapper,
    input  logic [3:0]                          offset,
    input  logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_size,
    input  msx_cart_pkg::bank_set_t             banks,
    output logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_addr,
    output logic                                rom_valid
);
    import msx_cart_pkg::*;

    logic                  banked;
    logic                  in_window;
    logic [1:0]            slot;
    logic [7:0]            slot_bank;
    logic [ROM_SIZE_W-1:0] bank_addr;
    logic [15:0]           base;
    logic                  above_base;
    logic [ROM_SIZE_W-1:0] plain_addr;
    logic                  plain_ok;
    logic [ROM_SIZE_W-1:0] next_addr;
    logic                  next_valid;

    // ************************************************************************
    // Banked translation
    // ************************************************************************
    assign banked    = mapper != MAPPER_UNUSED;
    assign in_window = cpu.addr[15:14] == 2'b01 || cpu.addr[15:14] == 2'b10;
    assign slot      = 2'(cpu.addr[15:13] - 3'd2);  // 0x4000 is slot 0.

    always_comb begin
        case (slot)
            2'd0:    slot_bank = banks.bank0;
            2'd1:    slot_bank = banks.bank1;
            2'd2:    slot_bank = banks.bank2;
            default: slot_bank = banks.bank3;
        endcase
    end

    // Banked images are a power of two long, so the mask wraps large bank numbers.
    assign bank_addr = ROM_SIZE_W'({slot_bank, cpu.addr[12:0]}) & (rom_size - 1'b1);

    // ************************************************************************
    // Plain ROM translation
    // ************************************************************************
    assign base       = {offset, 12'h000};
    assign above_base = cpu.addr >= base;
    assign plain_addr = ROM_SIZE_W'(cpu.addr - base);
    assign plain_ok   = above_base && plain_addr < rom_size;

    always_comb begin
        if (banked) begin
            next_addr  = bank_addr;
            next_valid = in_window;
        end else begin
            next_addr  = plain_addr;
            next_valid = plain_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rom_valid <= 1'b0;
        end else begin
            rom_valid <= cpu.rd && next_valid;  // High for one cycle per read.
        end
    end

    always_ff @(posedge clk) begin
        if (cpu.rd) begin
            rom_addr <= next_addr;
        end
    end

endmodule

/* source/msx_cart_top.sv */
`timescale 1ns/1ps

module msx_cart_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [7:0]                          load_data,
    input  logic                                load_wr,
    input  logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_size,
    input  msx_cart_pkg::cpu_bus_t              cpu,
    output msx_cart_pkg::mapper_typ_t           mapper,
    output logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_addr,
    output logic                                rom_valid
);
    import msx_cart_pkg::*;

    logic [3:0] offset;
    bank_wr_t   bank_wr;
    bank_set_t  banks;

    // Classifies the image while it streams in.
    mapper_detect i_mapper_detect (
        .clk      (clk),
        .rst      (rst),
        .data     (load_data),
        .wr       (load_wr),
        .rom_size (rom_size),
        .mapper   (mapper),
        .offset   (offset)
    );

    cart_bank_decode i_cart_bank_decode (
        .cpu     (cpu),
        .mapper  (mapper),
        .bank_wr (bank_wr)
    );

    cart_bank_regs i_cart_bank_regs (
        .clk     (clk),
        .rst     (rst),
        .bank_wr (bank_wr),
        .banks   (banks)
    );

    cart_read_map i_cart_read_map (
        .clk       (clk),
        .rst       (rst),
        .cpu       (cpu),
        .mapper    (mapper),
        .offset    (offset),
        .rom_size  (rom_size),
        .banks     (banks),
        .rom_addr  (rom_addr),
        .rom_valid (rom_valid)
    );

endmodule

/* verification/msx_cart_tb.sv */
`timescale 1ns/1ps

module msx_cart_tb;
    import msx_cart_pkg::*;

    localparam string TRACE_PATH = "verification/cart_trace.txt";
    localparam int    MAX_IMAGE  = 32'h20000;
    localparam int    NO_WIN     = 32'h10000;  // Start address that no CPU cycle can reach.

    logic                  clk = 1'b0;
    logic                  rst;
    logic [7:0]            load_data;
    logic                  load_wr;
    logic [ROM_SIZE_W-1:0] rom_size;
    cpu_bus_t              cpu;
    mapper_typ_t           mapper;
    logic [ROM_SIZE_W-1:0] rom_addr;
    logic                  rom_valid;

    logic [7:0]  image [MAX_IMAGE];
    int          image_size;
    logic [7:0]  model_bank [4];  // Reference copy of the four 8 KB bank numbers.
    mapper_typ_t model_mapper;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    msx_cart_top i_msx_cart_top (
        .clk       (clk),
        .rst       (rst),
        .load_data (load_data),
        .load_wr   (load_wr),
        .rom_size  (rom_size),
        .cpu       (cpu),
        .mapper    (mapper),
        .rom_addr  (rom_addr),
        .rom_valid (rom_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("Timeout: the trace did not finish in %0d cycles.", cycle_limit));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped after the first error.");
    endtask

    task automatic fail_value(input string name, input int expected, input int actual);
        $display("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h",
                 $time, name, expected, actual);
        abort_run("A DUT output differs from its expected value.");
    endtask

    // ************************************************************************
    // Reference rules
    // ************************************************************************
    // Filler mixes every address bit and never produces the store opcode.
    function automatic logic [7:0] fill_byte(input int addr, input logic [7:0] seed);
        logic [7:0] b;
        b = seed ^ addr[7:0] ^ {addr[12:8], addr[15:13]} ^ {addr[16], 7'h00};
        if (b == 8'h32) b = 8'h23;
        return b;
    endfunction

    // Index of the bank register that a write hits, or -1 outside every 2 KB window.
    function automatic int window_index(input mapper_typ_t m, input int addr);
        int starts [4];
        int i;
        case (m)
            MAPPER_KONAMI:     starts = '{NO_WIN, 'h6000, 'h8000, 'hA000};
            MAPPER_KONAMI_SCC: starts = '{'h5000, 'h7000, 'h9000, 'hB000};
            MAPPER_ASCII8:     starts = '{'h6000, 'h6800, 'h7000, 'h7800};
            MAPPER_ASCII16:    starts = '{'h6000, 'h7000, NO_WIN, NO_WIN};
            default:           starts = '{NO_WIN, NO_WIN, NO_WIN, NO_WIN};
        endcase
        for (i = 0; i < 4; i++) begin
            if (addr >= starts[i] && addr < starts[i] + 2048) return i;
        end
        return -1;
    endfunction

    // ************************************************************************
    // Stimulus tasks that start and end on a falling edge
    // ************************************************************************
    task automatic start_image(input int size, input logic [7:0] seed);
        int i;
        if (size > MAX_IMAGE) abort_run("A trace image is larger than the image buffer.");
        image_size = size;
        for (i = 0; i < size; i++) begin
            image[17'(i)] = fill_byte(i, seed);
        end
        model_mapper = MAPPER_UNUSED;
        for (i = 0; i < 4; i++) begin
            model_bank[2'(i)] = 8'(i);  // Bank registers come out of reset as 0 to 3.
        end
        rst      = 1'b1;
        rom_size = ROM_SIZE_W'(size);
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic load_image();
        int i;
        for (i = 0; i < image_size; i++) begin
            load_data = image[17'(i)];
            load_wr   = 1'b1;
            @(negedge clk);
        end
        load_wr = 1'b0;
    endtask

    task automatic check_mapper(input int expected);
        model_mapper = mapper_typ_t'(expected[2:0]);
        assert (mapper === model_mapper) else fail_value("mapper", expected, 32'(mapper));
    endtask

    task automatic cpu_write(input int addr, input int value);
        int idx;
        idx      = window_index(model_mapper, addr);
        cpu.addr = 16'(addr);
        cpu.data = value[7:0];
        cpu.wr   = 1'b1;
        @(negedge clk);
        cpu.wr = 1'b0;
        if (idx >= 0 && model_mapper == MAPPER_ASCII16) begin
            model_bank[2'(2 * idx)]     = 8'(2 * value);      // 16 KB bank fills a slot pair.
            model_bank[2'(2 * idx + 1)] = 8'(2 * value + 1);
        end else if (idx >= 0) begin
            model_bank[2'(idx)] = value[7:0];
        end
    endtask

    task automatic cpu_read(input int addr, input int exp_addr, input int exp_valid);
        bit banked_read;
        int model_addr;
        banked_read = model_mapper != MAPPER_UNUSED && addr >= 'h4000 && addr < 'hC000;
        model_addr  = 0;
        if (banked_read) begin
            model_addr = int'(model_bank[2'((addr - 'h4000) / 8192)]) * 8192 + addr % 8192;
            model_addr = model_addr % image_size;
        end
        cpu.addr = 16'(addr);
        cpu.rd   = 1'b1;
        @(negedge clk);
        cpu.rd = 1'b0;
        assert (rom_valid === exp_valid[0])
            else fail_value("rom_valid", exp_valid, 32'(rom_valid));
        if (exp_valid[0]) begin
            assert (rom_addr === ROM_SIZE_W'(exp_addr))
                else fail_value("rom_addr", exp_addr, 32'(rom_addr));
        end
        if (banked_read) begin
            assert (rom_addr === ROM_SIZE_W'(model_addr))
                else fail_value("rom_addr", model_addr, 32'(rom_addr));
        end
    endtask

    // ************************************************************************
    // Trace reader that also sizes the timeout in a pass without stimulus
    // ************************************************************************
    task automatic run_trace(input bit execute, output int cycles);
        int    fd;
        int    n;
        int    want;
        int    c;
        int    a0;
        int    a1;
        int    a2;
        string kind;
        cycles = 0;
        fd     = $fopen(TRACE_PATH, "r");
        if (fd == 0) abort_run("The trace file could not be opened.");
        while ($fscanf(fd, "%s", kind) == 1) begin
            n    = 0;
            want = 0;
            if (kind == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) c = $fgetc(fd);
            end else if (kind == "I") begin
                want   = 2;
                n      = $fscanf(fd, "%h %h", a0, a1);
                cycles += a0 + 4;
                if (execute) start_image(a0, a1[7:0]);
            end else if (kind == "B" || kind == "S") begin
                want = 2;
                n    = $fscanf(fd, "%h %h", a0, a1);
                if (execute && kind == "S") begin
                    image[17'(a0)]     = 8'h32;  // ld (nn),a with a zero low byte.
                    image[17'(a0 + 1)] = 8'h00;
                    image[17'(a0 + 2)] = a1[7:0];
                end else if (execute) begin
                    image[17'(a0)] = a1[7:0];
                end
            end else if (kind == "L") begin
                if (execute) load_image();
            end else if (kind == "M") begin
                want = 1;
                n    = $fscanf(fd, "%h", a0);
                if (execute) check_mapper(a0);
            end else if (kind == "W") begin
                want   = 2;
                n      = $fscanf(fd, "%h %h", a0, a1);
                cycles += 1;
                if (execute) cpu_write(a0, a1);
            end else if (kind == "R") begin
                want   = 3;
                n      = $fscanf(fd, "%h %h %h", a0, a1, a2);
                cycles += 1;
                if (execute) cpu_read(a0, a1, a2);
            end else begin
                abort_run($sformatf("The trace holds an unknown record %s.", kind));
            end
            if (n != want) abort_run($sformatf("A %s record in the trace is incomplete.", kind));
        end
        $fclose(fd);
    endtask

    initial begin
        int total;
        rst       = 1'b0;
        load_data = 8'h00;
        load_wr   = 1'b0;
        rom_size  = '0;
        cpu       = '0;
        run_trace(1'b0, total);
        cycle_limit = 2 * total + 100;
        @(negedge clk);
        run_trace(1'b1, total);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verification/cart_trace.txt */
# I size fill | B pos byte | S pos hi (bytes 32 00 hi) | L load | M mapper (0 plain .. 4 ASCII16)
# W addr data | R addr rom_addr valid. All numbers are hex.
# 16 KB plain ROM, "AB" at 0x0000 with start 0x4010, placed at 0x4000.
I 4000 11  B 0 41  B 1 42  B 2 10  B 3 40  L  M 0
R 4000 0000 1  R 7fff 3fff 1  R 8000 0 0  R 3fff 0 0
# 16 KB plain ROM started from 0x8020, placed at 0x8000.
I 4000 27  B 0 41  B 1 42  B 2 20  B 3 80  L  M 0
R 8000 0000 1  R bfff 3fff 1  R 4000 0 0  R c000 0 0
# 32 KB plain ROM with "AB" only at 0x4000 and start 0x4010, placed at 0x0000.
I 8000 3c  B 0 00  B 1 00  B 4000 41  B 4001 42  B 4002 10  B 4003 40  L  M 0
R 0000 0000 1  R 7fff 7fff 1  R 8000 0 0
# 32 KB plain ROM with "AB" at 0x0000, placed at 0x4000; a write changes nothing.
I 8000 45  B 0 41  B 1 42  B 2 10  B 3 40  L  M 0
W 6000 05
R 4000 0000 1  R bfff 7fff 1  R 3fff 0 0  R c000 0 0
# 128 KB Konami SCC, stores to the SCC windows outvote the others.
I 20000 5a  S 1000 50  S 1100 70  S 1200 90  S 1300 b0  L  M 2
R 4000 0000 1  R 6123 2123 1  R 8000 4000 1  R bfff 7fff 1  R 3fff 0 0
W 5000 05  W 7000 0a  W 9000 13  W b7ff 0f  W 6000 07  W 5800 01
R 4010 a010 1  R 7fff 15fff 1  R 8abc 6abc 1  R a001 1e001 1  R c000 0 0
# 128 KB Konami without SCC, slot 0 stays fixed.
I 20000 6b  S 2000 80  S 2400 a0  S 2800 60  L  M 1
R 4000 0000 1  R a000 6000 1
W 6000 04  W 8000 09  W a000 0c  W 5000 07  W 4000 03
R 4100 0100 1  R 6200 8200 1  R 9fff 13fff 1  R b000 19000 1
# 64 KB ASCII8, stores to 0x68 and 0x78 tip the vote.
I 10000 7e  S 0800 68  S 0900 78  S 0a00 68  S 0b00 78  S 0c00 60  L  M 3
R a000 6000 1
W 6000 02  W 6800 05  W 7000 07  W 7fff 09  W 8000 01
R 4000 4000 1  R 6001 a001 1  R 8002 e002 1  R a003 2003 1  R c000 0 0
# 64 KB ASCII16, only 0x60 and 0x70 stores.
I 10000 8f  S 3000 60  S 3100 70  S 3200 60  S 3300 70  L  M 4
R 6000 2000 1  R 8000 4000 1
W 6000 03  W 7000 02  W 6800 05
R 4000 c000 1  R 6000 e000 1  R 8000 8000 1  R bfff bfff 1  R 2000 0 0

/* src.f */
source/msx_cart_pkg.sv
source/mapper_detect.sv
source/cart_bank_decode.sv
source/cart_bank_regs.sv
source/cart_read_map.sv
source/msx_cart_top.sv
verification/msx_cart_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module msx_cart_tb -Mdir obj_dir -f src.f
result=$(./obj_dir/Vmsx_cart_tb 2>&1) || true
printf '%s\n' "$result"
if printf '%s\n' "$result" | grep -qx 'Test completed successfully'; then
    exit 0
fi
exit 1
